// ==== hw/samp_filt_pkg.sv ====
package samp_filt_pkg;

  //////////////////////////////////////////////////
  // data path widths
  //////////////////////////////////////////////////

  // I and Q samples, two's complement
  localparam int samp_width = 12;

  // magnitude estimate and its average
  localparam int mag_width = 13;

  // pad length field
  localparam int pad_width = 4;

  localparam int num_chan = 4;

  //////////////////////////////////////////////////
  // register block
  //////////////////////////////////////////////////

  localparam int wb_adr_width = 2;

  // word addresses
  typedef enum logic [wb_adr_width-1:0] {
    reg_threshold = 2'd0,
    reg_pad       = 2'd1,
    reg_bypass    = 2'd2
  } reg_addr_e;

  // squelch gate states
  typedef enum logic [1:0] {
    gate_closed,
    gate_open,
    gate_hang
  } gate_state_e;

endpackage

// ==== hw/iq_magnitude.sv ====
module iq_magnitude (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                ena,
  input  logic [samp_filt_pkg::samp_width-1:0] i_in,
  input  logic [samp_filt_pkg::samp_width-1:0] q_in,
  output logic [samp_filt_pkg::mag_width-1:0]  mag
);

  import samp_filt_pkg::*;

  localparam int abs_width = samp_width - 1;

  logic [abs_width-1:0] abs_i;
  logic [abs_width-1:0] abs_q;
  logic [abs_width-1:0] max_v;
  logic [abs_width-1:0] min_v;

  // absolute value, most negative code clips to full scale
  function automatic logic [abs_width-1:0] sat_abs(input logic [samp_width-1:0] x);
    logic [samp_width-1:0] neg;
    neg = -x;
    if (!x[samp_width-1]) return x[abs_width-1:0];
    else if (x[abs_width-1:0] == '0) return '1;
    else return neg[abs_width-1:0];
  endfunction

  assign abs_i = sat_abs(i_in);
  assign abs_q = sat_abs(q_in);
  assign max_v = (abs_i >= abs_q) ? abs_i : abs_q;
  assign min_v = (abs_i >= abs_q) ? abs_q : abs_i;

  // alpha = 1, beta = 1/2
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mag <= '0;
    end else if (ena) begin
      mag <= mag_width'(max_v) + mag_width'(min_v >> 1);
    end
  end

endmodule

// ==== hw/boxcar_avg.sv ====
module boxcar_avg #(
  parameter int log2_avg_len = 3
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               ena,
  input  logic [samp_filt_pkg::mag_width-1:0] din,
  output logic [samp_filt_pkg::mag_width-1:0] avg
);

  import samp_filt_pkg::*;

  localparam int avg_len   = 1 << log2_avg_len;
  // room for avg_len full scale values
  localparam int sum_width = mag_width + log2_avg_len;

  logic [mag_width-1:0] hist [avg_len];
  logic [sum_width-1:0] sum;

  //////////////////////////////////////////////////
  // running sum
  //////////////////////////////////////////////////

  // newest value in, oldest value out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum <= '0;
    end else if (ena) begin
      sum <= sum + sum_width'(din) - sum_width'(hist[avg_len-1]);
    end
  end

  // window history, starts empty so early steps count as zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < avg_len; i++) begin
        hist[i] <= '0;
      end
    end else if (ena) begin
      hist[0] <= din;
      for (int i = 1; i < avg_len; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // divide by window length
  assign avg = sum[sum_width-1:log2_avg_len];

endmodule

// ==== hw/squelch_gate.sv ====
module squelch_gate (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               ena,
  input  logic [samp_filt_pkg::mag_width-1:0] avg,
  input  logic [samp_filt_pkg::mag_width-1:0] threshold,
  input  logic [samp_filt_pkg::pad_width-1:0] pad_len,
  input  logic                               bypass,
  output logic                               valid_out
);

  import samp_filt_pkg::*;

  gate_state_e          state;
  logic [pad_width-1:0] hold_cnt;
  logic [pad_width-1:0] cnt_inc;
  logic                 pass;
  logic                 hold;
  logic                 open_now;

  assign pass     = avg > threshold;
  // still inside the pad after the last pass step
  assign hold     = hold_cnt < pad_len;
  assign open_now = pass || hold;
  assign cnt_inc  = hold_cnt + 1'b1;

  // counter parks at pad_len while closed
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= gate_closed;
      hold_cnt  <= pad_len;
      valid_out <= 1'b0;
    end else begin
      valid_out <= ena && (open_now || bypass);
      if (ena) begin
        if (pass) begin
          state    <= gate_open;
          hold_cnt <= '0;
        end else if (hold) begin
          hold_cnt <= cnt_inc;
          if (cnt_inc < pad_len) state <= gate_hang;
          else state <= gate_closed;
        end else begin
          state <= gate_closed;
        end
      end
    end
  end

endmodule

// ==== hw/sample_delay.sv ====
module sample_delay #(
  parameter int num_delay = 6
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                ena,
  input  logic [samp_filt_pkg::samp_width-1:0] i_in,
  input  logic [samp_filt_pkg::samp_width-1:0] q_in,
  output logic [samp_filt_pkg::samp_width-1:0] i_out,
  output logic [samp_filt_pkg::samp_width-1:0] q_out
);

  import samp_filt_pkg::*;

  logic [samp_width-1:0] i_dly [num_delay];
  logic [samp_width-1:0] q_dly [num_delay];

  // output register holds between valid steps
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < num_delay; n++) begin
        i_dly[n] <= '0;
        q_dly[n] <= '0;
      end
      i_out <= '0;
      q_out <= '0;
    end else if (ena) begin
      i_dly[0] <= i_in;
      q_dly[0] <= q_in;
      for (int n = 1; n < num_delay; n++) begin
        i_dly[n] <= i_dly[n-1];
        q_dly[n] <= q_dly[n-1];
      end
      i_out <= i_dly[num_delay-1];
      q_out <= q_dly[num_delay-1];
    end
  end

endmodule

// ==== hw/samp_filt_chan.sv ====
module samp_filt_chan #(
  parameter int log2_avg_len = 3,
  parameter int num_delay    = 6
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                valid_in,
  input  logic [samp_filt_pkg::samp_width-1:0] i_in,
  input  logic [samp_filt_pkg::samp_width-1:0] q_in,
  input  logic [samp_filt_pkg::mag_width-1:0]  threshold,
  input  logic [samp_filt_pkg::pad_width-1:0]  pad_len,
  input  logic                                bypass,
  output logic                                valid_out,
  output logic [samp_filt_pkg::samp_width-1:0] i_out,
  output logic [samp_filt_pkg::samp_width-1:0] q_out
);

  import samp_filt_pkg::*;

  logic [mag_width-1:0] mag;
  logic [mag_width-1:0] avg;

  // every stage steps on valid_in only
  iq_magnitude u_mag (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (valid_in),
    .i_in  (i_in),
    .q_in  (q_in),
    .mag   (mag)
  );

  boxcar_avg #(
    .log2_avg_len (log2_avg_len)
  ) u_avg (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (valid_in),
    .din   (mag),
    .avg   (avg)
  );

  squelch_gate u_gate (
    .clk       (clk),
    .rst_n     (rst_n),
    .ena       (valid_in),
    .avg       (avg),
    .threshold (threshold),
    .pad_len   (pad_len),
    .bypass    (bypass),
    .valid_out (valid_out)
  );

  // data path, lines up samples with the gate decision
  sample_delay #(
    .num_delay (num_delay)
  ) u_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (valid_in),
    .i_in  (i_in),
    .q_in  (q_in),
    .i_out (i_out),
    .q_out (q_out)
  );

endmodule

// ==== hw/squelch_regs.sv ====
module squelch_regs #(
  parameter logic [samp_filt_pkg::mag_width-1:0] default_threshold = 200,
  parameter logic [samp_filt_pkg::pad_width-1:0] default_pad       = 3
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wb_cyc,
  input  logic                                  wb_stb,
  input  logic                                  wb_we,
  input  logic [samp_filt_pkg::wb_adr_width-1:0] wb_adr,
  input  logic [15:0]                           wb_dat_w,
  output logic [15:0]                           wb_dat_r,
  output logic                                  wb_ack,
  output logic [samp_filt_pkg::mag_width-1:0]    threshold,
  output logic [samp_filt_pkg::pad_width-1:0]    pad_len,
  output logic [samp_filt_pkg::num_chan-1:0]     bypass
);

  import samp_filt_pkg::*;

  reg_addr_e   addr;
  logic        req;
  logic [15:0] rd_data;

  assign addr = reg_addr_e'(wb_adr);
  // new request, ack not yet given
  assign req  = wb_cyc && wb_stb && !wb_ack;

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////

  always_comb begin
    case (addr)
      reg_threshold: rd_data = 16'(threshold);
      reg_pad:       rd_data = 16'(pad_len);
      reg_bypass:    rd_data = 16'(bypass);
      default:       rd_data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // ack and register writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack    <= 1'b0;
      wb_dat_r  <= '0;
      threshold <= default_threshold;
      pad_len   <= default_pad;
      bypass    <= '0;
    end else begin
      wb_ack <= req;
      if (req) begin
        wb_dat_r <= rd_data;
        // writes land on the same edge as the ack
        if (wb_we) begin
          case (addr)
            reg_threshold: threshold <= wb_dat_w[mag_width-1:0];
            reg_pad:       pad_len   <= wb_dat_w[pad_width-1:0];
            reg_bypass:    bypass    <= wb_dat_w[num_chan-1:0];
            default:       ;
          endcase
        end
      end
    end
  end

endmodule

// ==== hw/samp_filt_top.sv ====
module samp_filt_top #(
  parameter int log2_avg_len = 3,
  parameter int num_delay    = 6,
  parameter logic [samp_filt_pkg::mag_width-1:0] default_threshold = 200,
  parameter logic [samp_filt_pkg::pad_width-1:0] default_pad       = 3
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  valid_0_in,
  input  logic [samp_filt_pkg::samp_width-1:0]   i_0_in,
  input  logic [samp_filt_pkg::samp_width-1:0]   q_0_in,
  input  logic                                  valid_1_in,
  input  logic [samp_filt_pkg::samp_width-1:0]   i_1_in,
  input  logic [samp_filt_pkg::samp_width-1:0]   q_1_in,
  input  logic                                  valid_2_in,
  input  logic [samp_filt_pkg::samp_width-1:0]   i_2_in,
  input  logic [samp_filt_pkg::samp_width-1:0]   q_2_in,
  input  logic                                  valid_3_in,
  input  logic [samp_filt_pkg::samp_width-1:0]   i_3_in,
  input  logic [samp_filt_pkg::samp_width-1:0]   q_3_in,
  output logic                                  valid_0_out,
  output logic [samp_filt_pkg::samp_width-1:0]   i_0_out,
  output logic [samp_filt_pkg::samp_width-1:0]   q_0_out,
  output logic                                  valid_1_out,
  output logic [samp_filt_pkg::samp_width-1:0]   i_1_out,
  output logic [samp_filt_pkg::samp_width-1:0]   q_1_out,
  output logic                                  valid_2_out,
  output logic [samp_filt_pkg::samp_width-1:0]   i_2_out,
  output logic [samp_filt_pkg::samp_width-1:0]   q_2_out,
  output logic                                  valid_3_out,
  output logic [samp_filt_pkg::samp_width-1:0]   i_3_out,
  output logic [samp_filt_pkg::samp_width-1:0]   q_3_out,
  input  logic                                  wb_cyc,
  input  logic                                  wb_stb,
  input  logic                                  wb_we,
  input  logic [samp_filt_pkg::wb_adr_width-1:0] wb_adr,
  input  logic [15:0]                           wb_dat_w,
  output logic [15:0]                           wb_dat_r,
  output logic                                  wb_ack
);

  import samp_filt_pkg::*;

  logic [mag_width-1:0]  threshold;
  logic [pad_width-1:0]  pad_len;
  logic [num_chan-1:0]   bypass;

  logic [num_chan-1:0]   valid_in;
  logic [num_chan-1:0]   valid_out;
  logic [samp_width-1:0] i_in  [num_chan];
  logic [samp_width-1:0] q_in  [num_chan];
  logic [samp_width-1:0] i_out [num_chan];
  logic [samp_width-1:0] q_out [num_chan];

  //////////////////////////////////////////////////
  // channel port packing
  //////////////////////////////////////////////////

  assign valid_in = {valid_3_in, valid_2_in, valid_1_in, valid_0_in};
  assign i_in[0]  = i_0_in;
  assign q_in[0]  = q_0_in;
  assign i_in[1]  = i_1_in;
  assign q_in[1]  = q_1_in;
  assign i_in[2]  = i_2_in;
  assign q_in[2]  = q_2_in;
  assign i_in[3]  = i_3_in;
  assign q_in[3]  = q_3_in;

  assign {valid_3_out, valid_2_out, valid_1_out, valid_0_out} = valid_out;
  assign i_0_out = i_out[0];
  assign q_0_out = q_out[0];
  assign i_1_out = i_out[1];
  assign q_1_out = q_out[1];
  assign i_2_out = i_out[2];
  assign q_2_out = q_out[2];
  assign i_3_out = i_out[3];
  assign q_3_out = q_out[3];

  //////////////////////////////////////////////////
  // settings and channels
  //////////////////////////////////////////////////

  squelch_regs #(
    .default_threshold (default_threshold),
    .default_pad       (default_pad)
  ) u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .threshold (threshold),
    .pad_len   (pad_len),
    .bypass    (bypass)
  );

  // all channels share one threshold and pad length
  for (genvar n = 0; n < num_chan; n++) begin : chan_gen
    samp_filt_chan #(
      .log2_avg_len (log2_avg_len),
      .num_delay    (num_delay)
    ) u_chan (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid_in  (valid_in[n]),
      .i_in      (i_in[n]),
      .q_in      (q_in[n]),
      .threshold (threshold),
      .pad_len   (pad_len),
      .bypass    (bypass[n]),
      .valid_out (valid_out[n]),
      .i_out     (i_out[n]),
      .q_out     (q_out[n])
    );
  end

endmodule

// ==== bench/samp_filt_tb.sv ====
module samp_filt_tb;

  import samp_filt_pkg::*;

  localparam int log2_avg_len = 3;
  localparam int num_delay    = 6;
  localparam int def_thr      = 200;
  localparam int def_pad      = 3;
  localparam int hist_len     = 32;
  localparam int phase_cycles = 700;
  // three traffic phases
  localparam int stim_cycles  = 3 * phase_cycles;
  localparam int cycle_limit  = 2 * stim_cycles + 100;

  logic                  clk;
  logic                  rst_n;
  logic [num_chan-1:0]   valid_in;
  logic [samp_width-1:0] i_in  [num_chan];
  logic [samp_width-1:0] q_in  [num_chan];
  logic [num_chan-1:0]   valid_out;
  logic [samp_width-1:0] i_out [num_chan];
  logic [samp_width-1:0] q_out [num_chan];
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [wb_adr_width-1:0] wb_adr;
  logic [15:0]           wb_dat_w;
  logic [15:0]           wb_dat_r;
  logic                  wb_ack;

  logic [31:0]           lfsr;
  string                 test_name;
  int                    cycle_count = 0;
  int                    open_count;

  // register state as seen through acked writes
  int                    shadow_thr;
  int                    shadow_pad;
  logic [num_chan-1:0]   shadow_byp;

  // per channel model state
  int                    mag_ring  [num_chan][hist_len];
  logic [samp_width-1:0] i_ring    [num_chan][hist_len];
  logic [samp_width-1:0] q_ring    [num_chan][hist_len];
  int                    step_cnt  [num_chan];
  int                    hold_cnt  [num_chan];
  bit                    exp_valid [num_chan];
  logic [samp_width-1:0] exp_i     [num_chan];
  logic [samp_width-1:0] exp_q     [num_chan];
  int                    burst_left [num_chan];
  bit                    loud       [num_chan];

  samp_filt_top #(
    .log2_avg_len      (log2_avg_len),
    .num_delay         (num_delay),
    .default_threshold (13'(def_thr)),
    .default_pad       (4'(def_pad))
  ) u_samp_filt_top (
    .clk (clk), .rst_n (rst_n),
    .valid_0_in (valid_in[0]), .i_0_in (i_in[0]), .q_0_in (q_in[0]),
    .valid_1_in (valid_in[1]), .i_1_in (i_in[1]), .q_1_in (q_in[1]),
    .valid_2_in (valid_in[2]), .i_2_in (i_in[2]), .q_2_in (q_in[2]),
    .valid_3_in (valid_in[3]), .i_3_in (i_in[3]), .q_3_in (q_in[3]),
    .valid_0_out (valid_out[0]), .i_0_out (i_out[0]), .q_0_out (q_out[0]),
    .valid_1_out (valid_out[1]), .i_1_out (i_out[1]), .q_1_out (q_out[1]),
    .valid_2_out (valid_out[2]), .i_2_out (i_out[2]), .q_2_out (q_out[2]),
    .valid_3_out (valid_out[3]), .i_3_out (i_out[3]), .q_3_out (q_out[3]),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin : watchdog
    wait (cycle_count >= cycle_limit);
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  //////////////////////////////////////////////////
  // random stimulus
  //////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // quiet noise within 15, loud around 1500
  function automatic logic [samp_width-1:0] draw_sample(input bit big);
    int mag;
    mag = big ? 1400 + int'(take_bits(7)) : int'(take_bits(4));
    if (take_bits(1) != 0) mag = -mag;
    return samp_width'(mag);
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic int abs_sat(input logic [samp_width-1:0] x);
    int v;
    v = int'($signed(x));
    if (v < 0) v = -v;
    if (v > (1 << (samp_width - 1)) - 1) v = (1 << (samp_width - 1)) - 1;
    return v;
  endfunction

  function automatic int ref_magnitude(input logic [samp_width-1:0] iv,
                                      input logic [samp_width-1:0] qv);
    int ai;
    int aq;
    ai = abs_sat(iv);
    aq = abs_sat(qv);
    return (ai >= aq) ? ai + aq / 2 : aq + ai / 2;
  endfunction

  // boxcar average ending at step j, steps before 0 are zero
  function automatic int ref_average(input int ch, input int j);
    int sum;
    sum = 0;
    for (int t = j - (1 << log2_avg_len) + 1; t <= j; t++) begin
      if (t >= 0) sum += mag_ring[ch][t % hist_len];
    end
    return sum >> log2_avg_len;
  endfunction

  // one accepted sample in, expected {valid, i, q} out
  function automatic logic [2*samp_width:0] ref_step(input int ch,
                                                     input logic [samp_width-1:0] iv,
                                                     input logic [samp_width-1:0] qv);
    int                    k;
    int                    old;
    bit                    pass;
    bit                    open;
    logic [samp_width-1:0] di;
    logic [samp_width-1:0] dq;
    k = step_cnt[ch];
    mag_ring[ch][k % hist_len] = ref_magnitude(iv, qv);
    i_ring[ch][k % hist_len] = iv;
    q_ring[ch][k % hist_len] = qv;
    step_cnt[ch] = k + 1;
    pass = ref_average(ch, k - 2) > shadow_thr;
    if (pass) begin
      open = 1'b1;
      hold_cnt[ch] = 0;
    end else if (hold_cnt[ch] < shadow_pad) begin
      open = 1'b1;
      hold_cnt[ch]++;
    end else begin
      open = 1'b0;
    end
    old = k - num_delay;
    di = (old >= 0) ? i_ring[ch][old % hist_len] : '0;
    dq = (old >= 0) ? q_ring[ch][old % hist_len] : '0;
    return {open || shadow_byp[ch], di, dq};
  endfunction

  task automatic init_model();
    shadow_thr = def_thr;
    shadow_pad = def_pad;
    shadow_byp = '0;
    open_count = 0;
    for (int ch = 0; ch < num_chan; ch++) begin
      for (int t = 0; t < hist_len; t++) begin
        mag_ring[ch][t] = 0;
        i_ring[ch][t] = '0;
        q_ring[ch][t] = '0;
      end
      step_cnt[ch] = 0;
      hold_cnt[ch] = def_pad;
      exp_valid[ch] = 1'b0;
      exp_i[ch] = '0;
      exp_q[ch] = '0;
      burst_left[ch] = 0;
      loud[ch] = 1'b0;
    end
  endtask

  task automatic expect_equal(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("ERROR %s %s: expected %0d actual %0d", test_name, what, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////
  // output compare, mid cycle
  //////////////////////////////////////////////////

  initial begin : compare_outputs
    logic [2*samp_width:0] pred;
    bit                    prev_ack;
    prev_ack = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      for (int ch = 0; ch < num_chan; ch++) begin
        expect_equal($sformatf("ch%0d valid_out", ch), int'(exp_valid[ch]),
                     int'(valid_out[ch]));
        expect_equal($sformatf("ch%0d i_out", ch), int'(exp_i[ch]), int'(i_out[ch]));
        expect_equal($sformatf("ch%0d q_out", ch), int'(exp_q[ch]), int'(q_out[ch]));
        if (valid_out[ch]) open_count++;
      end
      expect_equal("wb_ack width", 0, int'(prev_ack && wb_ack));
      prev_ack = wb_ack;
      // write landed on the edge that raised ack
      if (wb_ack && wb_we) begin
        case (wb_adr)
          reg_threshold: shadow_thr = int'(wb_dat_w[mag_width-1:0]);
          reg_pad:       shadow_pad = int'(wb_dat_w[pad_width-1:0]);
          reg_bypass:    shadow_byp = wb_dat_w[num_chan-1:0];
          default:       ;
        endcase
      end
      for (int ch = 0; ch < num_chan; ch++) begin
        if (valid_in[ch]) begin
          pred = ref_step(ch, i_in[ch], q_in[ch]);
          exp_valid[ch] = pred[2*samp_width];
          exp_i[ch] = pred[2*samp_width-1:samp_width];
          exp_q[ch] = pred[samp_width-1:0];
        end else begin
          exp_valid[ch] = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // bus and traffic tasks
  //////////////////////////////////////////////////

  task automatic wb_transfer(input bit we, input int adr, input int data, output int rdata);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr[wb_adr_width-1:0];
    wb_dat_w <= data[15:0];
    @(negedge clk);
    waited = 0;
    while (!wb_ack) begin
      @(negedge clk);
      waited++;
    end
    rdata = int'(wb_dat_r);
    expect_equal("wb ack latency", 1, waited);
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic reg_write(input int adr, input int data);
    int unused;
    wb_transfer(1'b1, adr, data, unused);
  endtask

  task automatic reg_read_check(input int adr, input int expected, input string what);
    int rdata;
    wb_transfer(1'b0, adr, 0, rdata);
    expect_equal(what, expected, rdata);
  endtask

  // bursts of loud or quiet samples, valid about 3 of 4 cycles
  task automatic run_traffic(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      for (int ch = 0; ch < num_chan; ch++) begin
        if (burst_left[ch] == 0) begin
          loud[ch] = take_bits(2) == 0;
          burst_left[ch] = loud[ch] ? 1 + int'(take_bits(4)) : 16 + int'(take_bits(5));
        end
        burst_left[ch]--;
        valid_in[ch] <= take_bits(2) != 0;
        i_in[ch] <= draw_sample(loud[ch]);
        q_in[ch] <= draw_sample(loud[ch]);
      end
    end
    @(posedge clk);
    valid_in <= '0;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : run_tests
    clk      = 1'b0;
    rst_n    = 1'b0;
    valid_in = '0;
    for (int ch = 0; ch < num_chan; ch++) begin
      i_in[ch] = '0;
      q_in[ch] = '0;
    end
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    lfsr     = 32'h25d2;
    init_model();

    test_name = "reset";
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_equal("wb_ack", 0, int'(wb_ack));
    expect_equal("valid_out", 0, int'(valid_out));

    test_name = "defaults";
    reg_read_check(reg_threshold, def_thr, "threshold");
    reg_read_check(reg_pad, def_pad, "pad_len");
    reg_read_check(reg_bypass, 0, "bypass");
    reg_read_check(3, 0, "unused address");

    test_name = "squelch_default";
    run_traffic(phase_cycles);
    assert (open_count > 0) else begin
      $display("no channel gate opened during the loud bursts");
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end

    // settings change while samples keep flowing
    test_name = "new_pad_threshold";
    fork
      run_traffic(phase_cycles);
      begin
        repeat (100) @(posedge clk);
        reg_write(reg_pad, 7);
        reg_write(reg_threshold, 400);
      end
    join
    reg_read_check(reg_pad, 7, "pad_len");
    reg_read_check(reg_threshold, 400, "threshold");

    test_name = "bypass_ch2";
    reg_write(reg_bypass, 4'b0100);
    run_traffic(phase_cycles);
    reg_read_check(reg_bypass, 4, "bypass");

    repeat (num_delay + 4) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== flist.f ====
hw/samp_filt_pkg.sv
hw/iq_magnitude.sv
hw/boxcar_avg.sv
hw/squelch_gate.sv
hw/sample_delay.sv
hw/samp_filt_chan.sv
hw/squelch_regs.sv
hw/samp_filt_top.sv
bench/samp_filt_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the squelch testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module samp_filt_tb -f flist.f \
  -o samp_filt_sim \
  && ./obj_dir/samp_filt_sim | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
